/* hdl/iic_display_pkg.sv */
`default_nettype none

package iic_display_pkg;

    // byte-level commands understood by the bus engine
    typedef enum logic [2:0] {
        INST_NONE  = 3'd0,
        INST_START = 3'd1,
        INST_SEND  = 3'd2,
        INST_RECV  = 3'd3,
        INST_STOP  = 3'd4
    } iic_inst_t;

    typedef logic [7:0] byte_t;

    localparam int NUM_DIGITS = 4;

    // digit 0 is the ones digit
    typedef logic [NUM_DIGITS-1:0][7:0] seg_digits_t;

    // eeprom device address, direction bit cleared
    localparam byte_t EEPROM_DEV_ADDR = 8'hA0;
    localparam byte_t IIC_READ_BIT = 8'h01;

    // tm1650 control register and brightness / display on
    localparam byte_t TM1650_CTRL_ADDR = 8'h24;
    localparam byte_t TM1650_DISPLAY_ON = 8'h15;

    // digit registers, rightmost digit first
    localparam byte_t TM1650_DIGIT_ADDR [NUM_DIGITS] = '{
        8'h37, 8'h36, 8'h35, 8'h34
    };

    // common cathode codes for 0..9, no decimal point
    localparam byte_t SEG_CODE [10] = '{
        8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66,
        8'h6d, 8'h7d, 8'h07, 8'h7f, 8'h6f
    };

endpackage

`default_nettype wire

/* hdl/iic_cmd_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface iic_cmd_if;
    import iic_display_pkg::*;

    logic      cmd_valid;
    iic_inst_t cmd_inst;
    byte_t     cmd_byte;
    byte_t     rd_byte;
    logic      cmd_done;

    // side that issues commands
    modport issuer (
        output cmd_valid,
        output cmd_inst,
        output cmd_byte,
        input  rd_byte,
        input  cmd_done
    );

    // side that executes them
    modport engine (
        input  cmd_valid,
        input  cmd_inst,
        input  cmd_byte,
        output rd_byte,
        output cmd_done
    );

endinterface

`default_nettype wire

/* hdl/digit_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

module digit_encoder (
    input  iic_display_pkg::byte_t      value,
    output iic_display_pkg::seg_digits_t segments
);
    import iic_display_pkg::*;

    logic [3:0] dec [NUM_DIGITS];

    // decimal split, a byte never exceeds three digits
    always_comb begin
        dec[0] = 4'(value % 8'd10);
        dec[1] = 4'((value / 8'd10) % 8'd10);
        dec[2] = 4'(value / 8'd100);
        dec[3] = 4'd0;
    end

    // leading zeros are shown as well
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            segments[i] = SEG_CODE[dec[i]];
        end
    end

endmodule

`default_nettype wire

/* hdl/eeprom_reader.sv */
`timescale 1ns/1ns
`default_nettype none

module eeprom_reader (
    input  logic                   in_clk,
    input  logic                   in_rst,
    input  logic                   start,
    iic_cmd_if.issuer              cmd,
    output iic_display_pkg::byte_t data,
    output logic                   done
);
    import iic_display_pkg::*;

    typedef enum logic [2:0] {
        R_IDLE,
        R_START,
        R_DEV_WR,
        R_ADDR,
        R_RESTART,
        R_DEV_RD,
        R_RECV,
        R_STOP
    } step_t;

    step_t state;
    step_t next_step;
    logic  issued;
    byte_t addr;

    // random read: dummy write of the word address, then read back
    always_comb begin
        case (state)
            R_START:   next_step = R_DEV_WR;
            R_DEV_WR:  next_step = R_ADDR;
            R_ADDR:    next_step = R_RESTART;
            R_RESTART: next_step = R_DEV_RD;
            R_DEV_RD:  next_step = R_RECV;
            R_RECV:    next_step = R_STOP;
            default:   next_step = R_IDLE;
        endcase
    end

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            state <= R_IDLE;
            issued <= 1'b0;
            done <= 1'b0;
            addr <= 8'd0;
        end else begin
            done <= 1'b0;
            if (state == R_IDLE) begin
                issued <= 1'b0;
                if (start) begin
                    state <= R_START;
                end
            end else if (cmd.cmd_done) begin
                state <= next_step;
                issued <= 1'b0;
                if (state == R_STOP) begin
                    done <= 1'b1;
                    addr <= addr + 8'd1;
                end
            end else if (cmd.cmd_valid) begin
                issued <= 1'b1;
            end
        end
    end

    always_ff @(posedge in_clk) begin
        if (state == R_RECV && cmd.cmd_done) begin
            data <= cmd.rd_byte;
        end
    end

    // one command per step, held back until the engine answers
    assign cmd.cmd_valid = (state != R_IDLE) && !issued;

    always_comb begin
        case (state)
            R_START, R_RESTART:       cmd.cmd_inst = INST_START;
            R_DEV_WR, R_ADDR, R_DEV_RD: cmd.cmd_inst = INST_SEND;
            R_RECV:                   cmd.cmd_inst = INST_RECV;
            R_STOP:                   cmd.cmd_inst = INST_STOP;
            default:                  cmd.cmd_inst = INST_NONE;
        endcase
    end

    always_comb begin
        case (state)
            R_DEV_WR: cmd.cmd_byte = EEPROM_DEV_ADDR;
            R_ADDR:   cmd.cmd_byte = addr;
            R_DEV_RD: cmd.cmd_byte = EEPROM_DEV_ADDR | IIC_READ_BIT;
            default:  cmd.cmd_byte = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/display_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module display_writer (
    input  logic                   in_clk,
    input  logic                   in_rst,
    input  logic                   start,
    input  iic_display_pkg::byte_t value,
    iic_cmd_if.issuer              cmd,
    output logic                   done
);
    import iic_display_pkg::*;

    typedef enum logic [2:0] {
        W_IDLE,
        W_START,
        W_ADDR,
        W_DATA,
        W_STOP
    } step_t;

    step_t       state;
    logic        issued;
    logic [1:0]  digit;
    logic        setup_done;
    seg_digits_t segments;

    digit_encoder i_digit_encoder (
        .value    (value),
        .segments (segments)
    );

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            state <= W_IDLE;
            issued <= 1'b0;
            digit <= 2'd0;
            setup_done <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                W_IDLE: begin
                    issued <= 1'b0;
                    if (start) begin
                        digit <= 2'd0;
                        state <= W_START;
                    end
                end
                W_START, W_ADDR, W_DATA: begin
                    if (cmd.cmd_done) begin
                        issued <= 1'b0;
                        state <= state.next();
                    end else if (cmd.cmd_valid) begin
                        issued <= 1'b1;
                    end
                end
                W_STOP: begin
                    if (cmd.cmd_done) begin
                        issued <= 1'b0;
                        if (!setup_done) begin
                            // control write done, digits follow
                            setup_done <= 1'b1;
                            state <= W_START;
                        end else if (digit == 2'(NUM_DIGITS - 1)) begin
                            done <= 1'b1;
                            state <= W_IDLE;
                        end else begin
                            digit <= digit + 2'd1;
                            state <= W_START;
                        end
                    end else if (cmd.cmd_valid) begin
                        issued <= 1'b1;
                    end
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

    assign cmd.cmd_valid = (state != W_IDLE) && !issued;

    always_comb begin
        case (state)
            W_START:        cmd.cmd_inst = INST_START;
            W_ADDR, W_DATA: cmd.cmd_inst = INST_SEND;
            W_STOP:         cmd.cmd_inst = INST_STOP;
            default:        cmd.cmd_inst = INST_NONE;
        endcase
    end

    // setup transaction until the first stop, digit transactions after
    always_comb begin
        case (state)
            W_ADDR:  cmd.cmd_byte = setup_done ? TM1650_DIGIT_ADDR[digit] : TM1650_CTRL_ADDR;
            W_DATA:  cmd.cmd_byte = setup_done ? segments[digit] : TM1650_DISPLAY_ON;
            default: cmd.cmd_byte = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/sequence_control.sv */
`timescale 1ns/1ns
`default_nettype none

module sequence_control (
    input  logic      in_clk,
    input  logic      in_rst,
    input  logic      trigger,
    output logic      busy,
    output logic      reader_start,
    input  logic      reader_done,
    output logic      writer_start,
    input  logic      writer_done,
    iic_cmd_if.engine reader_if,
    iic_cmd_if.engine writer_if,
    iic_cmd_if.issuer bus_if
);
    import iic_display_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_SHOW
    } state_t;

    state_t state;

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            state <= S_IDLE;
            reader_start <= 1'b0;
            writer_start <= 1'b0;
        end else begin
            reader_start <= 1'b0;
            writer_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    // triggers during a run never get here
                    if (trigger) begin
                        state <= S_FETCH;
                        reader_start <= 1'b1;
                    end
                end
                S_FETCH: begin
                    if (reader_done) begin
                        state <= S_SHOW;
                        writer_start <= 1'b1;
                    end
                end
                S_SHOW: begin
                    if (writer_done) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign busy = (state != S_IDLE);

    // bus ownership follows the run phase
    always_comb begin
        bus_if.cmd_valid = 1'b0;
        bus_if.cmd_inst = INST_NONE;
        bus_if.cmd_byte = 8'h00;
        reader_if.cmd_done = 1'b0;
        reader_if.rd_byte = 8'h00;
        writer_if.cmd_done = 1'b0;
        writer_if.rd_byte = 8'h00;
        case (state)
            S_FETCH: begin
                bus_if.cmd_valid = reader_if.cmd_valid;
                bus_if.cmd_inst = reader_if.cmd_inst;
                bus_if.cmd_byte = reader_if.cmd_byte;
                reader_if.cmd_done = bus_if.cmd_done;
                reader_if.rd_byte = bus_if.rd_byte;
            end
            S_SHOW: begin
                bus_if.cmd_valid = writer_if.cmd_valid;
                bus_if.cmd_inst = writer_if.cmd_inst;
                bus_if.cmd_byte = writer_if.cmd_byte;
                writer_if.cmd_done = bus_if.cmd_done;
                writer_if.rd_byte = bus_if.rd_byte;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/eeprom_display_top.sv */
`timescale 1ns/1ns
`default_nettype none

module eeprom_display_top (
    input  logic                       in_clk,
    input  logic                       in_rst,
    input  logic                       trigger,
    output logic                       busy,
    output logic                       cmd_valid,
    output iic_display_pkg::iic_inst_t cmd_inst,
    output iic_display_pkg::byte_t     cmd_byte,
    input  iic_display_pkg::byte_t     rd_byte,
    input  logic                       cmd_done
);
    import iic_display_pkg::*;

    logic  reader_start;
    logic  reader_done;
    logic  writer_start;
    logic  writer_done;
    byte_t read_data;

    iic_cmd_if reader_if ();
    iic_cmd_if writer_if ();
    iic_cmd_if bus_if ();

    eeprom_reader i_eeprom_reader (
        .in_clk (in_clk),
        .in_rst (in_rst),
        .start  (reader_start),
        .cmd    (reader_if.issuer),
        .data   (read_data),
        .done   (reader_done)
    );

    display_writer i_display_writer (
        .in_clk (in_clk),
        .in_rst (in_rst),
        .start  (writer_start),
        .value  (read_data),
        .cmd    (writer_if.issuer),
        .done   (writer_done)
    );

    sequence_control i_sequence_control (
        .in_clk       (in_clk),
        .in_rst       (in_rst),
        .trigger      (trigger),
        .busy         (busy),
        .reader_start (reader_start),
        .reader_done  (reader_done),
        .writer_start (writer_start),
        .writer_done  (writer_done),
        .reader_if    (reader_if.engine),
        .writer_if    (writer_if.engine),
        .bus_if       (bus_if.issuer)
    );

    // engine side of the bus leaves the design here
    assign cmd_valid = bus_if.cmd_valid;
    assign cmd_inst = bus_if.cmd_inst;
    assign cmd_byte = bus_if.cmd_byte;
    assign bus_if.rd_byte = rd_byte;
    assign bus_if.cmd_done = cmd_done;

endmodule

`default_nettype wire

/* bench/iic_engine_model.sv */
`timescale 1ns/1ns
`default_nettype none

module iic_engine_model (
    input  logic                       in_clk,
    input  logic                       in_rst,
    input  logic                       cmd_valid,
    input  iic_display_pkg::iic_inst_t cmd_inst,
    input  iic_display_pkg::byte_t     cmd_byte,
    output iic_display_pkg::byte_t     rd_byte,
    output logic                       cmd_done
);
    import iic_display_pkg::*;

    localparam logic [16:0] LFSR_SEED = 17'd66830;

    // eeprom content, loaded from the testbench top
    byte_t       mem [256];
    // every command seen on the bus, in order
    iic_inst_t   log_inst [$];
    byte_t       log_byte [$];
    int          violations;

    logic [16:0] lfsr;
    int          wait_left;
    logic        pending;
    iic_inst_t   pend_inst;
    logic        addr_next;
    byte_t       word_addr;

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    initial begin
        lfsr = LFSR_SEED;
        violations = 0;
        pending = 1'b0;
        wait_left = 0;
        addr_next = 1'b0;
        word_addr = 8'h00;
        pend_inst = INST_NONE;
        rd_byte = 8'h00;
        cmd_done = 1'b0;
    end

    always @(negedge in_clk) begin
        logic [2:0] bits;
        cmd_done <= 1'b0;
        if (in_rst) begin
            pending = 1'b0;
            wait_left = 0;
            addr_next = 1'b0;
        end else if (pending) begin
            // issuer must hold off until done
            if (cmd_valid) begin
                violations++;
            end
            if (wait_left == 1) begin
                cmd_done <= 1'b1;
                pending = 1'b0;
                if (pend_inst == INST_RECV) begin
                    rd_byte <= mem[word_addr];
                end
            end
            wait_left--;
        end else if (cmd_valid) begin
            log_inst.push_back(cmd_inst);
            log_byte.push_back(cmd_byte);
            // word address follows the write-direction device address
            if (cmd_inst == INST_SEND) begin
                if (addr_next) begin
                    word_addr = cmd_byte;
                end
                addr_next = (cmd_byte == EEPROM_DEV_ADDR);
            end
            for (int i = 0; i < 3; i++) begin
                bits = {bits[1:0], lfsr[16]};
                lfsr = lfsr_step(lfsr);
            end
            wait_left = int'(bits) + 1;
            pend_inst = cmd_inst;
            pending = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* bench/tb_eeprom_display.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_eeprom_display;
    import iic_display_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT = 2000;

    logic      in_clk;
    logic      in_rst;
    logic      trigger;
    logic      busy;
    logic      cmd_valid;
    iic_inst_t cmd_inst;
    byte_t     cmd_byte;
    byte_t     rd_byte;
    logic      cmd_done;

    iic_inst_t exp_inst [$];
    byte_t     exp_byte [$];
    int        checked = 0;
    int        checks = 0;
    int        errors = 0;
    int        test_num = 0;
    logic      timed_out = 1'b0;

    eeprom_display_top i_dut (
        .in_clk    (in_clk),
        .in_rst    (in_rst),
        .trigger   (trigger),
        .busy      (busy),
        .cmd_valid (cmd_valid),
        .cmd_inst  (cmd_inst),
        .cmd_byte  (cmd_byte),
        .rd_byte   (rd_byte),
        .cmd_done  (cmd_done)
    );

    iic_engine_model i_engine (
        .in_clk    (in_clk),
        .in_rst    (in_rst),
        .cmd_valid (cmd_valid),
        .cmd_inst  (cmd_inst),
        .cmd_byte  (cmd_byte),
        .rd_byte   (rd_byte),
        .cmd_done  (cmd_done)
    );

    always #2 in_clk = ~in_clk;

    function automatic byte_t eeprom_value(input int a);
        return byte_t'((a * 37 + 11) % 256);
    endfunction

    function automatic void expect_cmd(input iic_inst_t inst, input byte_t b);
        exp_inst.push_back(inst);
        exp_byte.push_back(b);
    endfunction

    // run n reads address n and shows its value
    function automatic void build_expected(input int n);
        int value;
        int dig;
        value = int'(eeprom_value(n));
        expect_cmd(INST_START, 8'h00);
        expect_cmd(INST_SEND, EEPROM_DEV_ADDR);
        expect_cmd(INST_SEND, byte_t'(n));
        expect_cmd(INST_START, 8'h00);
        expect_cmd(INST_SEND, EEPROM_DEV_ADDR | IIC_READ_BIT);
        expect_cmd(INST_RECV, 8'h00);
        expect_cmd(INST_STOP, 8'h00);
        if (n == 0) begin
            expect_cmd(INST_START, 8'h00);
            expect_cmd(INST_SEND, TM1650_CTRL_ADDR);
            expect_cmd(INST_SEND, TM1650_DISPLAY_ON);
            expect_cmd(INST_STOP, 8'h00);
        end
        for (int k = 0; k < NUM_DIGITS; k++) begin
            dig = value % 10;
            value = value / 10;
            expect_cmd(INST_START, 8'h00);
            expect_cmd(INST_SEND, TM1650_DIGIT_ADDR[k]);
            expect_cmd(INST_SEND, SEG_CODE[dig]);
            expect_cmd(INST_STOP, 8'h00);
        end
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_inst(input string name, input iic_inst_t got, input iic_inst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %s (%0d) expected %s (%0d)",
                     $time, name, got.name(), got, exp.name(), exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // logged commands against the expected list, in order
    always @(negedge in_clk) begin
        iic_inst_t ei;
        byte_t     eb;
        while (checked < i_engine.log_inst.size()) begin
            if (exp_inst.size() == 0) begin
                ei = i_engine.log_inst[checked];
                errors++;
                $display("error at %0t ns: command %s was issued but none was expected",
                         $time, ei.name());
            end else begin
                ei = exp_inst.pop_front();
                eb = exp_byte.pop_front();
                check_inst("cmd_inst", i_engine.log_inst[checked], ei);
                if (ei == INST_SEND) begin
                    check_byte("cmd_byte", i_engine.log_byte[checked], eb);
                end
            end
            checked++;
        end
    end

    task automatic check_idle();
        check_bit("cmd_valid", cmd_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_inst("cmd_inst", cmd_inst, INST_NONE);
    endtask

    task automatic wait_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < WAIT_LIMIT) begin
            @(negedge in_clk);
            cycles++;
        end
        if (busy !== level) begin
            timed_out = 1'b1;
            $display("timeout at %0t ns: busy did not %s within %0d cycles",
                     $time, what, WAIT_LIMIT);
        end
    endtask

    // stray > 0 pulses a second trigger that many cycles into the run
    task automatic run_once(input int n, input int stray);
        if (timed_out) begin
            return;
        end
        build_expected(n);
        trigger = 1'b1;
        @(negedge in_clk);
        trigger = 1'b0;
        // busy follows an accepted trigger by one cycle
        check_bit("busy", busy, 1'b1);
        wait_busy(1'b1, "rise");
        if (stray > 0 && !timed_out) begin
            repeat (stray) @(negedge in_clk);
            check_bit("busy", busy, 1'b1);
            trigger = 1'b1;
            @(negedge in_clk);
            trigger = 1'b0;
        end
        wait_busy(1'b0, "fall");
        @(negedge in_clk);
        if (!timed_out && exp_inst.size() != 0) begin
            errors++;
            $display("error at %0t ns: run %0d ended with %0d expected commands missing",
                     $time, n, exp_inst.size());
        end
        exp_inst.delete();
        exp_byte.delete();
    endtask

    task automatic end_test(input string name, input int mark);
        test_num++;
        if (errors == mark && !timed_out) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - mark);
        end
    endtask

    initial begin
        int mark;
        in_clk = 1'b0;
        in_rst = 1'b1;
        trigger = 1'b0;
        for (int a = 0; a < 256; a++) begin
            i_engine.mem[a] = eeprom_value(a);
        end

        mark = errors;
        repeat (RESET_CYCLES) begin
            @(negedge in_clk);
            check_idle();
        end
        in_rst = 1'b0;
        repeat (8) begin
            @(negedge in_clk);
            check_idle();
        end
        end_test("reset and idle", mark);

        mark = errors;
        run_once(0, 0);
        end_test("run 0 with setup", mark);

        mark = errors;
        run_once(1, 0);
        end_test("run 1 without setup", mark);

        // second trigger lands mid-run and must vanish
        mark = errors;
        run_once(2, 5);
        repeat (6) begin
            @(negedge in_clk);
            check_idle();
        end
        run_once(3, 0);
        end_test("trigger while busy", mark);

        mark = errors;
        for (int n = 4; n < 24; n++) begin
            run_once(n, 0);
        end
        end_test("twenty back-to-back runs", mark);

        checks++;
        if (i_engine.violations != 0) begin
            errors++;
            $display("error: engine saw %0d commands while another was outstanding",
                     i_engine.violations);
        end
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/iic_display_pkg.sv
hdl/iic_cmd_if.sv
hdl/digit_encoder.sv
hdl/eeprom_reader.sv
hdl/display_writer.sv
hdl/sequence_control.sv
hdl/eeprom_display_top.sv
bench/iic_engine_model.sv
bench/tb_eeprom_display.sv
